/* list.f */
+incdir+common
common/riscv_pkg.sv
fetch/fetch_unit.sv
decode/controller.sv
decode/imm_ext.sv
execute/reg_file.sv
execute/alu.sv
rtl/data_mem.sv
rtl/riscv_core.sv
test/tb_clock.sv
test/tb_riscv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_riscv_core -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

# exit status is non-zero unless the pass line is present
echo "$output" | grep -q "Result: PASSED"

/* test/tb_riscv_core.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module tb_riscv_core;
    localparam int PERIOD_NS  = 100;
    localparam int PROG_WORDS = 256;
    localparam riscv_pkg::word_t NOP = 32'h0000_0013;   // addi x0, x0, 0

    // cycle budget per test, reset pulse counted separately
    localparam int CYC_REG = 40;
    localparam int CYC_IMM = 40;
    localparam int CYC_MEM = 20;
    localparam int CYC_BR  = 110;
    localparam int CYC_JMP = 30;
    localparam int CYC_RST = 20;
    localparam int WATCHDOG_CYCLES = CYC_REG + CYC_IMM + CYC_MEM + CYC_BR + CYC_JMP + CYC_RST
                                     + 6 * 5 + 50;

    // R-type order: add sub sll slt sltu xor srl sra or and
    localparam logic [29:0] R_F3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
    localparam logic [9:0]  R_ALT = 10'b00_1000_0010;  // sub and sra
    // beq bne blt bge bltu bgeu
    localparam logic [17:0] B_F3  = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

    logic             clk;
    logic             rst;
    logic             rst_por;
    logic             rst_test;
    riscv_pkg::word_t instr = NOP;
    riscv_pkg::word_t pc;
    logic             mem_we;
    riscv_pkg::word_t mem_addr;
    riscv_pkg::word_t mem_wdata;

    riscv_pkg::word_t prog [PROG_WORDS];
    riscv_pkg::word_t st_addr[$];
    riscv_pkg::word_t st_data[$];
    riscv_pkg::word_t st_pc[$];
    riscv_pkg::word_t exp_addr[$];
    riscv_pkg::word_t exp_data[$];
    riscv_pkg::word_t exp_pc[$];
    logic [15:0]      lfsr_state = 16'd83;
    int               checks;
    int               errors;
    int               tests;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(3)) clk_gen (.clk(clk), .rst(rst_por));

    assign rst = rst_por | rst_test;

    riscv_core uut (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    // instruction memory, nop outside the program
    always @(negedge clk) begin
        instr <= (pc[31:10] == '0) ? prog[pc[9:2]] : NOP;
    end

    function automatic riscv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_R_TYPE};
    endfunction

    function automatic riscv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_S_TYPE};
    endfunction

    function automatic riscv_pkg::word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_B_TYPE};
    endfunction

    function automatic riscv_pkg::word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_J_TYPE};
    endfunction

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic riscv_pkg::word_t rand_bits(input int n);
        riscv_pkg::word_t v;
        logic             fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic riscv_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I arithmetic, alt selects sub / sra
    function automatic riscv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                                 input riscv_pkg::word_t a,
                                                 input riscv_pkg::word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input riscv_pkg::word_t a,
                                          input riscv_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(input string name, input riscv_pkg::word_t got,
                              input riscv_pkg::word_t want);
        checks++;
        assert (got === want)
            else begin
                $display("Fail %s: got %h expected %h", name, got, want);
                errors++;
            end
    endtask

    task automatic start_test();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = NOP;
        end
        st_addr.delete();
        st_data.delete();
        st_pc.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
    endtask

    task automatic reset_core();
        @(negedge clk);
        rst_test = 1'b1;
        repeat (3) @(negedge clk);
        rst_test = 1'b0;
    endtask

    // collects stores until the expected count, then compares
    task automatic run_and_check(input int max_cycles, input logic check_pc);
        int cycles;
        int n;
        cycles = 0;
        n = exp_addr.size();
        while (st_addr.size() < n && cycles < max_cycles) begin
            @(posedge clk);     // pre-edge values of the executing instruction
            if (mem_we) begin
                st_addr.push_back(mem_addr);
                st_data.push_back(mem_wdata);
                st_pc.push_back(pc);
            end
            cycles++;
        end
        checks++;
        assert (st_addr.size() == n)
            else begin
                $display("expected %0d stores but saw %0d within %0d cycles",
                         n, st_addr.size(), max_cycles);
                errors++;
            end
        for (int k = 0; k < st_addr.size(); k++) begin
            check_word("mem_addr", st_addr[k], exp_addr[k]);
            check_word("mem_wdata", st_data[k], exp_data[k]);
            if (check_pc) begin
                check_word("pc", st_pc[k], exp_pc[k]);
            end
        end
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_reg_ops();
        logic [11:0] ia;
        logic [11:0] ib;
        logic [2:0]  f3;
        int          err0;
        err0 = errors;
        start_test();
        ia = 12'(rand_bits(12));
        ib = 12'(rand_bits(12));
        prog[0] = enc_i(ia, 0, 3'd0, 1, `OP_I_TYPE);
        prog[1] = enc_i(ib, 0, 3'd0, 2, `OP_I_TYPE);
        for (int k = 0; k < 10; k++) begin
            f3 = R_F3[3*k +: 3];
            prog[2 + 2*k] = enc_r({1'b0, R_ALT[k], 5'b0}, 2, 1, f3, 3);
            prog[3 + 2*k] = enc_s(12'(64 + 4*k), 3, 0);
            exp_addr.push_back(32'(64 + 4*k));
            exp_data.push_back(ref_alu(f3, R_ALT[k], sext12(ia), sext12(ib)));
        end
        reset_core();
        run_and_check(CYC_REG, 1'b0);
        report("reg_ops", err0);
    endtask

    task automatic test_imm_ops();
        logic [11:0]      r1;
        logic [11:0]      r2;
        logic [2:0]       f3s [10];
        logic [11:0]      imms [10];
        riscv_pkg::word_t a;
        int               err0;
        err0 = errors;
        start_test();
        r1 = 12'(rand_bits(12));
        r2 = 12'(rand_bits(12));
        a = (sext12(r1) << 12) + sext12(r2);
        // addi min/max, xori, ori, andi, slti, sltiu, slli, srli, srai
        f3s  = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        imms = '{12'h800, 12'h7ff, 12'hfff, 12'h800, 12'h7ff, 12'hfff, 12'hfff, 12'd31,
                 {7'h00, 5'(rand_bits(5))}, {7'h20, 5'(rand_bits(5))}};
        prog[0] = enc_i(r1, 0, 3'd0, 1, `OP_I_TYPE);
        prog[1] = enc_i(12'd12, 1, 3'd1, 1, `OP_I_TYPE);
        prog[2] = enc_i(r2, 1, 3'd0, 1, `OP_I_TYPE);
        for (int k = 0; k < 10; k++) begin
            prog[3 + 2*k] = enc_i(imms[k], 1, f3s[k], 3, `OP_I_TYPE);
            prog[4 + 2*k] = enc_s(12'(128 + 4*k), 3, 0);
            exp_addr.push_back(32'(128 + 4*k));
            exp_data.push_back(ref_alu(f3s[k], f3s[k] == 3'd5 && imms[k][10], a,
                                       sext12(imms[k])));
        end
        reset_core();
        run_and_check(CYC_IMM, 1'b0);
        report("imm_ops", err0);
    endtask

    task automatic test_load_store();
        logic [11:0]      r1;
        logic [11:0]      r2;
        riscv_pkg::word_t w;
        int               err0;
        err0 = errors;
        start_test();
        r1 = 12'(rand_bits(12));
        r2 = 12'(rand_bits(12));
        w = (sext12(r1) << 20) ^ sext12(r2);
        prog[0] = enc_i(r1, 0, 3'd0, 1, `OP_I_TYPE);
        prog[1] = enc_i(12'd20, 1, 3'd1, 1, `OP_I_TYPE);
        prog[2] = enc_i(r2, 1, 3'd4, 1, `OP_I_TYPE);
        prog[3] = enc_i(12'h100, 0, 3'd0, 5, `OP_I_TYPE);
        prog[4] = enc_s(12'hff0, 1, 5);                         // sw x1, -16(x5)
        prog[5] = enc_i(12'hff0, 5, 3'd2, 4, `OP_I_TYPE_L);     // lw x4, -16(x5)
        prog[6] = enc_s(12'd8, 4, 5);
        exp_addr.push_back(32'h0f0);
        exp_data.push_back(w);
        exp_addr.push_back(32'h108);
        exp_data.push_back(w);
        reset_core();
        run_and_check(CYC_MEM, 1'b0);
        report("load_store", err0);
    endtask

    task automatic test_branches();
        logic [11:0] va [3];
        logic [11:0] vb [3];
        logic [11:0] eq;
        logic [11:0] neg;
        logic [11:0] pos;
        logic [2:0]  f3;
        int          ip;
        int          ns;
        int          err0;
        err0 = errors;
        start_test();
        eq  = 12'(rand_bits(12));
        neg = ~12'(rand_bits(10));     // -1 .. -1024
        pos = 12'(rand_bits(10));
        va = '{eq, neg, pos};          // equal, signed-less, unsigned-less
        vb = '{eq, pos, neg};
        ip = 0;
        ns = 0;
        for (int p = 0; p < 3; p++) begin
            prog[ip]     = enc_i(va[p], 0, 3'd0, 1, `OP_I_TYPE);
            prog[ip + 1] = enc_i(vb[p], 0, 3'd0, 2, `OP_I_TYPE);
            ip += 2;
            for (int j = 0; j < 6; j++) begin
                f3 = B_F3[3*j +: 3];
                prog[ip]     = enc_i(12'd1, 0, 3'd0, 3, `OP_I_TYPE);   // taken marker
                prog[ip + 1] = enc_b(13'd8, 2, 1, f3);
                prog[ip + 2] = enc_i(12'd0, 0, 3'd0, 3, `OP_I_TYPE);   // skipped if taken
                prog[ip + 3] = enc_s(12'(256 + 4*ns), 3, 0);
                exp_addr.push_back(32'(256 + 4*ns));
                exp_data.push_back(32'(branch_taken(f3, sext12(va[p]), sext12(vb[p]))));
                ip += 4;
                ns++;
            end
        end
        reset_core();
        run_and_check(CYC_BR, 1'b0);
        report("branches", err0);
    endtask

    task automatic test_jumps();
        riscv_pkg::word_t jpc [3];
        riscv_pkg::word_t tgt [3];
        int               err0;
        err0 = errors;
        start_test();
        jpc = '{32'h00, 32'h14, 32'h34};
        tgt = '{32'h0c, (32'h2e + 32'd3) & ~32'd1, 32'h20};
        prog[0]  = enc_j(21'd12, 1);                            // jal x1, +12
        prog[3]  = enc_s(12'h040, 1, 0);
        prog[4]  = enc_i(12'h02e, 0, 3'd0, 6, `OP_I_TYPE);
        prog[5]  = enc_i(12'd3, 6, 3'd0, 2, `OP_JALR);          // odd sum
        prog[12] = enc_s(12'h044, 2, 0);
        prog[13] = enc_j(21'(-20), 3);                          // backward jal
        prog[8]  = enc_s(12'h048, 3, 0);
        for (int k = 0; k < 3; k++) begin
            exp_addr.push_back(32'(64 + 4*k));
            exp_data.push_back(jpc[k] + 32'd4);
            exp_pc.push_back(tgt[k]);
        end
        reset_core();
        run_and_check(CYC_JMP, 1'b1);
        report("jumps", err0);
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        start_test();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = enc_s(12'h0c0, 1, 0);     // sw x1, 0xc0(x0) everywhere
        end
        @(negedge clk);
        rst_test = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_word("mem_we", 32'(mem_we), 32'd0);
        end
        @(negedge clk);
        rst_test = 1'b0;
        check_word("pc", pc, 32'd0);
        exp_addr.push_back(32'h0c0);
        exp_data.push_back(32'd0);              // x1 cleared by reset
        exp_pc.push_back(32'd0);
        run_and_check(CYC_RST, 1'b1);
        report("reset", err0);
    endtask

    initial begin
        rst_test = 1'b0;
        checks = 0;
        errors = 0;
        tests = 0;
        start_test();
        test_reg_ops();
        test_imm_ops();
        test_load_store();
        test_branches();
        test_jumps();
        test_reset();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD_NS);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module riscv_core (
    input  logic             clk,
    input  logic             rst,
    input  riscv_pkg::word_t instr,
    output riscv_pkg::word_t pc,
    output logic             mem_we,
    output riscv_pkg::word_t mem_addr,
    output riscv_pkg::word_t mem_wdata
);
    riscv_pkg::ctrl_t      ctrl;
    riscv_pkg::alu_op_t    alu_ctrl;
    riscv_pkg::alu_flags_t alu_flags;
    riscv_pkg::word_t      imm;
    riscv_pkg::word_t      rd1, rd2;
    riscv_pkg::word_t      src_b;
    riscv_pkg::word_t      alu_result;
    riscv_pkg::word_t      read_data;
    riscv_pkg::word_t      result;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .pc_src(ctrl.pc_src),
        .imm_ext(imm), .alu_result(alu_result), .pc(pc)
    );

    controller u_ctrl (
        .instr(instr), .alu_flags(alu_flags), .ctrl(ctrl), .alu_ctrl(alu_ctrl)
    );

    imm_ext u_imm (.instr(instr), .imm_src(ctrl.imm_src), .imm_ext(imm));

    reg_file u_rf (
        .clk(clk), .rst(rst), .we(ctrl.reg_we),
        .ra1(instr[19:15]), .ra2(instr[24:20]), .wa(instr[11:7]),
        .wd(result), .rd1(rd1), .rd2(rd2)
    );

    assign src_b = (ctrl.alu_src == `ALU_SRC_EXT_IMM) ? imm : rd2;

    alu u_alu (
        .a(rd1), .b(src_b), .alu_ctrl(alu_ctrl), .result(alu_result), .flags(alu_flags)
    );

    // no store may land while the core is held in reset
    assign mem_we    = ctrl.mem_we & ~rst;
    assign mem_addr  = alu_result;
    assign mem_wdata = rd2;

    data_mem u_dmem (
        .clk(clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(read_data)
    );

    always_comb begin
        case (ctrl.result_src)
            `RES_SRC_READ_DATA: result = read_data;
            `RES_SRC_PC_PLUS_4: result = pc + 32'd4;   // link for jal / jalr
            default:            result = alu_result;
        endcase
    end

endmodule

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module data_mem (
    input  logic             clk,
    input  logic             we,
    input  riscv_pkg::word_t addr,      // byte address
    input  riscv_pkg::word_t wdata,
    output riscv_pkg::word_t rdata
);
    localparam int AW = $clog2(`DMEM_WORDS);

    riscv_pkg::word_t mem [`DMEM_WORDS];
    logic [AW-1:0]    idx;

    // word index, byte offset dropped (addr[9:2] for 256 words)
    assign idx = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];    // combinational read

    // address comes from rs1 + imm through the ALU, only words are supported
    a_store_aligned: assert property (@(posedge clk) we |-> addr[1:0] == 2'b00)
        else $error("misaligned store to %h", addr);

endmodule

/* execute/alu.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module alu (
    input  riscv_pkg::word_t      a,
    input  riscv_pkg::word_t      b,
    input  riscv_pkg::alu_op_t    alu_ctrl,
    output riscv_pkg::word_t      result,
    output riscv_pkg::alu_flags_t flags
);
    logic             sub_en;
    riscv_pkg::word_t b_eff;
    riscv_pkg::word_t sum;
    logic             cout;
    logic             ov;
    logic             lt_signed;

    // one adder serves add, sub and both compares
    assign sub_en = (alu_ctrl == `ALU_OP_SUB) || (alu_ctrl == `ALU_OP_SLT) ||
                    (alu_ctrl == `ALU_OP_SLTU);
    assign b_eff  = sub_en ? ~b : b;

    assign {cout, sum} = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub_en};

    // operands of equal sign, result of the other
    assign ov        = (a[31] == b_eff[31]) && (sum[31] != a[31]);
    assign lt_signed = sum[31] ^ ov;

    always_comb begin
        case (alu_ctrl)
            `ALU_OP_ADD,
            `ALU_OP_SUB:  result = sum;
            `ALU_OP_AND:  result = a & b;
            `ALU_OP_OR:   result = a | b;
            `ALU_OP_XOR:  result = a ^ b;
            `ALU_OP_SLL:  result = a << b[4:0];
            `ALU_OP_SRL:  result = a >> b[4:0];
            `ALU_OP_SRA:  result = $signed(a) >>> b[4:0];
            `ALU_OP_SLT:  result = {31'b0, lt_signed};
            `ALU_OP_SLTU: result = {31'b0, ~cout};     // borrow means a < b
            default:      result = '0;
        endcase
    end

    // {negative, zero, carry-out, overflow}
    assign flags = {result[31], result == '0, cout, ov};

endmodule

/* execute/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  riscv_pkg::reg_addr_t  ra1,
    input  riscv_pkg::reg_addr_t  ra2,
    input  riscv_pkg::reg_addr_t  wa,
    input  riscv_pkg::word_t      wd,
    output riscv_pkg::word_t      rd1,
    output riscv_pkg::word_t      rd2
);
    riscv_pkg::word_t regs [32];

    // x0 is never written, it keeps its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];     // combinational reads
    assign rd2 = regs[ra2];

    // holds only if reset clears x0 and no later write ever reaches it
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (ra1 != '0 || rd1 == '0) && (ra2 != '0 || rd2 == '0))
        else $error("x0 read back non-zero");

endmodule

/* decode/imm_ext.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module imm_ext (
    input  riscv_pkg::word_t instr,
    input  logic [2:0]       imm_src,
    output riscv_pkg::word_t imm_ext
);
    logic sign;

    assign sign = instr[31];    // every format keeps the sign here

    always_comb begin
        case (imm_src)
            `IMM_SRC_STYPE:
                imm_ext = {{20{sign}}, instr[31:25], instr[11:7]};
            // branch offsets are in halfwords, bit 0 implied
            `IMM_SRC_BTYPE:
                imm_ext = {{19{sign}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            `IMM_SRC_JTYPE:
                imm_ext = {{11{sign}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            default:    // I-type
                imm_ext = {{20{sign}}, instr[31:20]};
        endcase
    end

endmodule

/* decode/controller.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module alu_dec (
    input  logic [6:0]          op,
    input  logic [2:0]          func3,
    input  logic [6:0]          func7,
    output riscv_pkg::alu_op_t  alu_ctrl
);
    riscv_pkg::alu_op_t arith_op;   // shared by R-type and I-type

    always_comb begin
        case (func3)
            // addi has no sub form, imm bits land in func7
            3'b000:  arith_op = (op == `OP_R_TYPE && func7[5]) ? `ALU_OP_SUB : `ALU_OP_ADD;
            3'b001:  arith_op = `ALU_OP_SLL;
            3'b010:  arith_op = `ALU_OP_SLT;
            3'b011:  arith_op = `ALU_OP_SLTU;
            3'b100:  arith_op = `ALU_OP_XOR;
            3'b101:  arith_op = func7[5] ? `ALU_OP_SRA : `ALU_OP_SRL;
            3'b110:  arith_op = `ALU_OP_OR;
            default: arith_op = `ALU_OP_AND;   // 3'b111
        endcase
    end

    always_comb begin
        case (op)
            `OP_R_TYPE,
            `OP_I_TYPE:   alu_ctrl = arith_op;
            `OP_I_TYPE_L,
            `OP_S_TYPE,
            `OP_J_TYPE,
            `OP_JALR:     alu_ctrl = `ALU_OP_ADD;     // address or target add
            `OP_B_TYPE:   alu_ctrl = `ALU_OP_SUB;     // flags of rs1 - rs2
            default:      alu_ctrl = 'x;
        endcase
    end

endmodule

module controller (
    input  riscv_pkg::word_t    instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t    ctrl,
    output riscv_pkg::alu_op_t  alu_ctrl
);
    logic [6:0] op;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       neg, zero, cout, ov;
    logic [1:0] pc_src_b;
    logic       op_known;

    assign op    = instr[6:0];
    assign func3 = instr[14:12];
    assign func7 = instr[31:25];

    assign {neg, zero, cout, ov} = alu_flags;

    alu_dec u_alu_dec (
        .op       (op),
        .func3    (func3),
        .func7    (func7),
        .alu_ctrl (alu_ctrl)
    );

    // branch outcome from the flags of rs1 - rs2
    always_comb begin
        case (func3)
            3'b000:  pc_src_b = zero        ? `PC_SRC_PLUS_OFF : `PC_SRC_PLUS_4;    // beq
            3'b001:  pc_src_b = zero        ? `PC_SRC_PLUS_4   : `PC_SRC_PLUS_OFF;  // bne
            3'b100:  pc_src_b = (neg ^ ov)  ? `PC_SRC_PLUS_OFF : `PC_SRC_PLUS_4;    // blt
            3'b101:  pc_src_b = (neg ^ ov)  ? `PC_SRC_PLUS_4   : `PC_SRC_PLUS_OFF;  // bge
            3'b110:  pc_src_b = cout        ? `PC_SRC_PLUS_4   : `PC_SRC_PLUS_OFF;  // bltu
            3'b111:  pc_src_b = cout        ? `PC_SRC_PLUS_OFF : `PC_SRC_PLUS_4;    // bgeu
            default: pc_src_b = `PC_SRC_PLUS_4;
        endcase
    end

    always_comb begin
        // unknown opcode falls through these: no writes, pc + 4
        ctrl            = '0;
        ctrl.alu_src    = `ALU_SRC_REG;
        ctrl.result_src = `RES_SRC_ALU_OUT;
        ctrl.pc_src     = `PC_SRC_PLUS_4;
        ctrl.imm_src    = `IMM_SRC_ITYPE;
        case (op)
            `OP_I_TYPE_L: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = `ALU_SRC_EXT_IMM;
                ctrl.result_src = `RES_SRC_READ_DATA;
            end
            `OP_I_TYPE: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = `ALU_SRC_EXT_IMM;
            end
            `OP_S_TYPE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.alu_src = `ALU_SRC_EXT_IMM;
                ctrl.imm_src = `IMM_SRC_STYPE;
            end
            `OP_R_TYPE: begin
                ctrl.reg_we = 1'b1;
            end
            `OP_B_TYPE: begin
                ctrl.pc_src  = pc_src_b;
                ctrl.imm_src = `IMM_SRC_BTYPE;
            end
            `OP_J_TYPE: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = `RES_SRC_PC_PLUS_4;    // link
                ctrl.pc_src     = `PC_SRC_PLUS_OFF;
                ctrl.imm_src    = `IMM_SRC_JTYPE;
            end
            `OP_JALR: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = `ALU_SRC_EXT_IMM;      // alu forms rs1 + imm
                ctrl.result_src = `RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = `PC_SRC_REG_PLUS_OFF;
            end
            default: ;
        endcase
    end

    assign op_known = (op == `OP_I_TYPE_L) || (op == `OP_I_TYPE) || (op == `OP_S_TYPE) ||
                      (op == `OP_R_TYPE)   || (op == `OP_B_TYPE) || (op == `OP_J_TYPE) ||
                      (op == `OP_JALR);

    // no clock here, so checked once the combinational inputs have settled
    always_comb begin
        if (op_known) begin
            assert final (!$isunknown(alu_ctrl) && alu_ctrl <= `ALU_OP_SLTU)
                else $error("alu_ctrl undefined for opcode %b", op);
        end
    end

endmodule

/* fetch/fetch_unit.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        pc_src,
    input  riscv_pkg::word_t  imm_ext,      // branch or jump offset
    input  riscv_pkg::word_t  alu_result,   // rs1 + imm for jalr
    output riscv_pkg::word_t  pc
);
    riscv_pkg::word_t pc_next;
    riscv_pkg::word_t pc_plus_4;
    riscv_pkg::word_t pc_plus_off;

    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_off = pc + imm_ext;

    always_comb begin
        case (pc_src)
            `PC_SRC_PLUS_OFF:     pc_next = pc_plus_off;
            `PC_SRC_REG_PLUS_OFF: pc_next = {alu_result[31:1], 1'b0};  // jalr drops bit 0
            default:              pc_next = pc_plus_4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // targets come from imm_ext and the ALU, so alignment depends on the whole datapath
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

/* common/riscv_pkg.sv */
package riscv_pkg;

    // plain vectors with a meaning of their own
    typedef logic [31:0] word_t;        // data, address or instruction
    typedef logic [4:0]  reg_addr_t;    // x0..x31
    typedef logic [3:0]  alu_op_t;      // one of the ALU_OP_* codes

    // flag order matters to the branch logic
    // bit 3 negative, bit 2 zero, bit 1 carry-out, bit 0 overflow
    typedef logic [3:0]  alu_flags_t;

    // everything the controller hands to the datapath in one cycle
    typedef struct packed {
        logic       reg_we;         // write rd at the edge
        logic       mem_we;         // write data memory at the edge
        logic       alu_src;        // ALU_SRC_* code
        logic [1:0] result_src;     // RES_SRC_* code
        logic [1:0] pc_src;         // PC_SRC_* code
        logic [2:0] imm_src;        // IMM_SRC_* code
    } ctrl_t;

endpackage

/* common/riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// major opcodes, instr[6:0]
`define OP_I_TYPE_L         7'b0000011  // lw
`define OP_I_TYPE           7'b0010011  // addi and friends
`define OP_S_TYPE           7'b0100011  // sw
`define OP_R_TYPE           7'b0110011
`define OP_B_TYPE           7'b1100011
`define OP_J_TYPE           7'b1101111  // jal
`define OP_JALR             7'b1100111

// ALU operations
`define ALU_OP_ADD          4'd0
`define ALU_OP_SUB          4'd1
`define ALU_OP_AND          4'd2
`define ALU_OP_OR           4'd3
`define ALU_OP_XOR          4'd4
`define ALU_OP_SLL          4'd5
`define ALU_OP_SRL          4'd6
`define ALU_OP_SRA          4'd7
`define ALU_OP_SLT          4'd8
`define ALU_OP_SLTU         4'd9    // highest valid code

// next pc selection
`define PC_SRC_PLUS_4       2'b00
`define PC_SRC_PLUS_OFF     2'b01
`define PC_SRC_REG_PLUS_OFF 2'b10

// write-back selection
`define RES_SRC_ALU_OUT     2'b00
`define RES_SRC_READ_DATA   2'b01
`define RES_SRC_PC_PLUS_4   2'b10

// second ALU operand
`define ALU_SRC_REG         1'b0
`define ALU_SRC_EXT_IMM     1'b1

// immediate formats
`define IMM_SRC_ITYPE       3'b000
`define IMM_SRC_STYPE       3'b001
`define IMM_SRC_BTYPE       3'b010
`define IMM_SRC_JTYPE       3'b011

`define DMEM_WORDS          256

`endif
